//--- issue.f
common/issue_pkg.sv
common/uop_if.sv
verilog/issue_dispatch.sv
verilog/busy_table.sv
issue_rs/issue_rs.sv
verilog/issue_top.sv
verification/issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= issue_tb
FILELIST  ?= issue.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

//--- verification/issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_tb;

   localparam int N_RAND     = 300;                  // Random phase micro-ops
   localparam int N_DIRECTED = 40;
   localparam int TIMEOUT_NS = ((N_RAND + N_DIRECTED) * 40 + 10) * 10;

   typedef struct packed
   {
      logic bcc;
      logic brel;
      logic breg;
   } class_t;

   typedef struct packed
   {
      issue_pkg::uop_t uop;
      logic            was_ready;                    // No pending source at accept
   } track_t;

   logic                          clk;
   logic                          rst_n;
   logic                          flush;
   logic                          in_valid;
   issue_pkg::uop_t               drv;               // Fields on the in_* ports
   logic                          in_ready;
   logic                          rob_ready;
   logic [issue_pkg::ROB_AW-1:0]  rob_free_id;
   logic                          rob_push;
   logic [issue_pkg::PC_W-1:0]    rob_push_pc;
   logic [issue_pkg::PRF_AW-1:0]  rob_push_prd;
   logic                          rob_push_prd_we;
   class_t                        push_cls;
   logic                          wb_valid;
   logic [issue_pkg::PRF_AW-1:0]  wb_prd;
   logic                          ro_ready;
   logic                          ro_valid;
   issue_pkg::uop_t               ro;

   track_t                        track [$];         // Accepted, not yet at ro
   logic [issue_pkg::PRF_AW-1:0]  wbq [$];           // Issued, waiting writeback
   logic [issue_pkg::PRF_N-1:0]   pending;           // Busy model
   int  val_errs;
   int  other_errs;
   int  gen_count;
   int  gen_limit;
   int  accept_count;
   int  ro_mode;                                     // 0 random, 1 held low
   int  rob_mode;                                    // 0 random, 1 high, 2 low
   bit  gen_en;
   bit  dense;
   bit  run;
   bit  flush_req;
   bit  consumed;
   bit  pushed;
   bit  after_flush;

   issue_top u_dut
   (
      .clk (clk), .rst_n (rst_n), .flush (flush), .in_valid (in_valid),
      .in_alu_op (drv.alu_op), .in_bru_op (drv.bru_op), .in_pc (drv.pc),
      .in_imm (drv.imm), .in_prs1 (drv.prs1), .in_prs1_re (drv.prs1_re),
      .in_prs2 (drv.prs2), .in_prs2_re (drv.prs2_re), .in_prd (drv.prd),
      .in_prd_we (drv.prd_we), .in_ready (in_ready), .rob_ready (rob_ready),
      .rob_free_id (rob_free_id), .rob_push (rob_push), .rob_push_pc (rob_push_pc),
      .rob_push_prd (rob_push_prd), .rob_push_prd_we (rob_push_prd_we),
      .rob_push_is_bcc (push_cls.bcc), .rob_push_is_brel (push_cls.brel),
      .rob_push_is_breg (push_cls.breg), .wb_valid (wb_valid), .wb_prd (wb_prd),
      .ro_ready (ro_ready), .ro_valid (ro_valid), .ro_alu_op (ro.alu_op),
      .ro_bru_op (ro.bru_op), .ro_pc (ro.pc), .ro_imm (ro.imm), .ro_prs1 (ro.prs1),
      .ro_prs1_re (ro.prs1_re), .ro_prs2 (ro.prs2), .ro_prs2_re (ro.prs2_re),
      .ro_prd (ro.prd), .ro_prd_we (ro.prd_we), .ro_rob_id (ro.rob_id)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Branch class expected on the ROB push
   function automatic class_t expected_class(issue_pkg::bru_op_t op);
      class_t c;
      c = '0;
      case (op)
         issue_pkg::BRU_BEQ, issue_pkg::BRU_BNE, issue_pkg::BRU_BGT,
         issue_pkg::BRU_BGTU, issue_pkg::BRU_BLE, issue_pkg::BRU_BLEU: c.bcc = 1'b1;
         issue_pkg::BRU_JMPREL: c.brel = 1'b1;
         issue_pkg::BRU_JMPREG: c.breg = 1'b1;
         default: c = '0;
      endcase
      return c;
   endfunction

   task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp)
      begin
         val_errs++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_class(class_t got, class_t exp);
      if (got !== exp)
      begin
         val_errs++;
         $display("FAIL %0t rob_push_class got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_uop(issue_pkg::uop_t got, issue_pkg::uop_t exp);
      if (got !== exp)
      begin
         val_errs++;
         $display("FAIL %0t ro_uop got %h expected %h", $time, got, exp);
      end
   endtask

   // Destination must not be pending nor read by anything in flight
   function automatic bit dest_free(logic [issue_pkg::PRF_AW-1:0] d, issue_pkg::uop_t u);
      if (pending[d] || u.prs1 == d || u.prs2 == d)
         return 1'b0;
      foreach (track[i])
         if (track[i].uop.prs1 == d || track[i].uop.prs2 == d)
            return 1'b0;
      return 1'b1;
   endfunction

   task automatic make_uop(output issue_pkg::uop_t u);
      logic [31:0] r;
      logic [3:0]  b;
      logic [issue_pkg::PRF_AW-1:0] d;
      r        = $urandom;
      u.alu_op = r[issue_pkg::ALU_OPW-1:0];
      b        = r[7:4];
      if (b > 4'd8)
         b = 4'd0;                                   // Mostly plain ALU ops
      u.bru_op = issue_pkg::bru_op_t'(b);
      r        = $urandom;
      u.pc     = r[issue_pkg::PC_W-1:0];
      u.imm    = $urandom;
      r        = $urandom;
      u.prs1    = r[4:0] & 5'd7;                     // Small pool for many hazards
      u.prs1_re = r[8];
      u.prs2    = r[14:10] & 5'd7;
      u.prs2_re = r[15];
      u.prd     = '0;
      u.prd_we  = 1'b0;
      u.rob_id  = '0;
      for (int t = 0; t < 16; t++)
      begin
         r = $urandom;
         d = r[4:0] & 5'd15;
         if (!u.prd_we && dest_free(d, u))
         begin
            u.prd    = d;
            u.prd_we = 1'b1;
         end
      end
   endtask

   // Stimulus driven 1 ns after each edge
   always @(posedge clk)
   begin
      logic [31:0] r;
      issue_pkg::uop_t u;
      #1;
      if (run)
      begin
         r     = $urandom;
         flush = flush_req;
         if (pushed)
            rob_free_id++;
         if (consumed || !in_valid)
         begin
            if (gen_en && gen_count < gen_limit && (dense || r[1:0] != 2'b00))
            begin
               make_uop(u);
               drv      = u;
               in_valid = 1'b1;
               gen_count++;
            end
            else
               in_valid = 1'b0;
         end
         consumed  = 1'b0;
         pushed    = 1'b0;
         rob_ready = (rob_mode == 1) || (rob_mode == 0 && r[3:2] != 2'b00);
         ro_ready  = !flush_req && ro_mode == 0 && r[5:4] != 2'b00;
         if (!flush_req && wbq.size() > 0 && r[6])
         begin
            wb_valid = 1'b1;
            wb_prd   = wbq.pop_front();
         end
         else
            wb_valid = 1'b0;
      end
   end

   // Compare process sampling at the edge
   always @(posedge clk)
   begin
      logic hs;
      int   idx;
      issue_pkg::uop_t exp;
      track_t ent;
      if (rst_n)
      begin
         hs = in_valid & in_ready;
         if (after_flush)
         begin
            check_val("ro_valid_after_flush", ro_valid, 0);
            check_val("in_ready_after_flush", in_ready, 0);
            after_flush = 1'b0;
         end
         check_val("rob_push", rob_push, hs & ~flush);
         if (hs)
            consumed = 1'b1;
         if (ro_valid && ro_ready)
         begin
            idx = -1;
            foreach (track[i])
               if (track[i].uop.rob_id == ro.rob_id)
                  idx = i;
            if (idx < 0)
            begin
               other_errs++;
               $display("Error at %0t: ro gave rob id %0d that was never accepted or was flushed",
                        $time, ro.rob_id);
            end
            else
            begin
               check_uop(ro, track[idx].uop);
               if ((ro.prs1_re && pending[ro.prs1]) || (ro.prs2_re && pending[ro.prs2]))
               begin
                  other_errs++;
                  $display("Error at %0t: rob id %0d issued before its producer wrote back",
                           $time, ro.rob_id);
               end
               for (int j = 0; j < idx; j++)
                  if (track[idx].was_ready && track[j].was_ready)
                  begin
                     other_errs++;
                     $display("Error at %0t: rob id %0d passed older ready rob id %0d",
                              $time, ro.rob_id, track[j].uop.rob_id);
                  end
               if (ro.prd_we)
                  wbq.push_back(ro.prd);
               track.delete(idx);
            end
         end
         if (wb_valid)
            pending[wb_prd] = 1'b0;
         if (hs && !flush)
         begin
            exp        = drv;
            exp.rob_id = rob_free_id;
            check_val("rob_push_pc", rob_push_pc, drv.pc);
            check_val("rob_push_prd", rob_push_prd, drv.prd);
            check_val("rob_push_prd_we", rob_push_prd_we, drv.prd_we);
            check_class(push_cls, expected_class(drv.bru_op));
            ent.uop       = exp;
            ent.was_ready = !(drv.prs1_re && pending[drv.prs1])
                            && !(drv.prs2_re && pending[drv.prs2]);
            track.push_back(ent);
            if (drv.prd_we)
               pending[drv.prd] = 1'b1;
            pushed = 1'b1;
            accept_count++;
         end
         if (flush)
         begin
            track.delete();                           // Everything in flight is gone
            wbq.delete();
            pending     = '0;
            after_flush = 1'b1;
         end
      end
   end

   task automatic flush_pulse();
      flush_req = 1'b1;
      @(posedge clk);
      flush_req    = 1'b0;
      accept_count = 0;
   endtask

   task automatic drain();
      while (track.size() != 0 || in_valid)
         @(posedge clk);
   endtask

   initial
   begin
      void'($urandom(32'h8bc5_66f1));
      rst_n        = 1'b0;
      flush        = 1'b0;
      in_valid     = 1'b0;
      drv          = '0;
      rob_ready    = 1'b0;
      rob_free_id  = '0;
      wb_valid     = 1'b0;
      wb_prd       = '0;
      ro_ready     = 1'b0;
      pending      = '0;
      val_errs     = 0;
      other_errs   = 0;
      gen_count    = 0;
      gen_limit    = N_RAND;
      accept_count = 0;
      ro_mode      = 0;
      rob_mode     = 0;
      gen_en       = 1'b0;
      dense        = 1'b0;
      run          = 1'b0;
      flush_req    = 1'b0;
      consumed     = 1'b0;
      pushed       = 1'b0;
      after_flush  = 1'b0;
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      run    = 1'b1;
      gen_en = 1'b1;
      for (int next_flush = 97; gen_count < N_RAND; )
      begin
         @(posedge clk);
         if (gen_count >= next_flush)
         begin
            flush_pulse();                             // Mid-stream flush
            next_flush += 97;
         end
      end
      gen_en = 1'b0;
      drain();
      // Fill every stage with register read stalled
      ro_mode   = 1;
      rob_mode  = 1;
      dense     = 1'b1;
      gen_limit = gen_count + N_DIRECTED;
      gen_en    = 1'b1;
      flush_pulse();
      repeat (30) @(posedge clk);
      check_val("accepted_with_ro_stalled", accept_count, issue_pkg::RS_DEPTH + 2);
      rob_mode     = 2;                                // ROB full
      ro_mode      = 0;
      accept_count = 0;
      repeat (20) @(posedge clk);
      check_val("accepted_with_rob_full", accept_count, 0);
      rob_mode = 0;
      dense    = 1'b0;
      while (gen_count < gen_limit)
         @(posedge clk);
      gen_en = 1'b0;
      drain();
      repeat (5) @(posedge clk);
      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Error: run did not finish within %0d ns, DUT stopped making progress",
               TIMEOUT_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         flush,
   input  logic                         in_valid,
   input  logic [issue_pkg::ALU_OPW-1:0] in_alu_op,
   input  issue_pkg::bru_op_t           in_bru_op,
   input  logic [issue_pkg::PC_W-1:0]   in_pc,
   input  logic [issue_pkg::DW-1:0]     in_imm,
   input  logic [issue_pkg::PRF_AW-1:0] in_prs1,
   input  logic                         in_prs1_re,
   input  logic [issue_pkg::PRF_AW-1:0] in_prs2,
   input  logic                         in_prs2_re,
   input  logic [issue_pkg::PRF_AW-1:0] in_prd,
   input  logic                         in_prd_we,
   output logic                         in_ready,
   input  logic                         rob_ready,
   input  logic [issue_pkg::ROB_AW-1:0] rob_free_id,
   output logic                         rob_push,
   output logic [issue_pkg::PC_W-1:0]   rob_push_pc,
   output logic [issue_pkg::PRF_AW-1:0] rob_push_prd,
   output logic                         rob_push_prd_we,
   output logic                         rob_push_is_bcc,
   output logic                         rob_push_is_brel,
   output logic                         rob_push_is_breg,
   input  logic                         wb_valid,
   input  logic [issue_pkg::PRF_AW-1:0] wb_prd,
   input  logic                         ro_ready,
   output logic                         ro_valid,
   output logic [issue_pkg::ALU_OPW-1:0] ro_alu_op,
   output issue_pkg::bru_op_t           ro_bru_op,
   output logic [issue_pkg::PC_W-1:0]   ro_pc,
   output logic [issue_pkg::DW-1:0]     ro_imm,
   output logic [issue_pkg::PRF_AW-1:0] ro_prs1,
   output logic                         ro_prs1_re,
   output logic [issue_pkg::PRF_AW-1:0] ro_prs2,
   output logic                         ro_prs2_re,
   output logic [issue_pkg::PRF_AW-1:0] ro_prd,
   output logic                         ro_prd_we,
   output logic [issue_pkg::ROB_AW-1:0] ro_rob_id
);

   issue_pkg::uop_t               in_uop;
   issue_pkg::uop_t               ro_uop;
   logic                          set_valid;
   logic [issue_pkg::PRF_AW-1:0]  set_prd;
   logic [issue_pkg::PRF_N-1:0]   busy;

   uop_if disp_rs ();                       // Dispatch register to station

   // ROB id comes from the ROB at dispatch
   assign in_uop = '{alu_op: in_alu_op, bru_op: in_bru_op, pc: in_pc, imm: in_imm,
                     prs1: in_prs1, prs1_re: in_prs1_re, prs2: in_prs2,
                     prs2_re: in_prs2_re, prd: in_prd, prd_we: in_prd_we,
                     rob_id: '0};

   issue_dispatch u_dispatch
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush            (flush),
      .in_valid         (in_valid),
      .in_uop           (in_uop),
      .in_ready         (in_ready),
      .rob_ready        (rob_ready),
      .rob_free_id      (rob_free_id),
      .rob_push         (rob_push),
      .rob_push_pc      (rob_push_pc),
      .rob_push_prd     (rob_push_prd),
      .rob_push_prd_we  (rob_push_prd_we),
      .rob_push_is_bcc  (rob_push_is_bcc),
      .rob_push_is_brel (rob_push_is_brel),
      .rob_push_is_breg (rob_push_is_breg),
      .set_valid        (set_valid),
      .set_prd          (set_prd),
      .disp_rs          (disp_rs.source)
   );

   busy_table u_busy
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .set_valid (set_valid),
      .set_prd   (set_prd),
      .wb_valid  (wb_valid),
      .wb_prd    (wb_prd),
      .busy      (busy)
   );

   issue_rs #(.DEPTH(issue_pkg::RS_DEPTH)) u_rs
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .busy     (busy),
      .disp_rs  (disp_rs.sink),
      .ro_ready (ro_ready),
      .ro_valid (ro_valid),
      .ro_uop   (ro_uop)
   );

   assign ro_alu_op  = ro_uop.alu_op;       // Flatten toward register read
   assign ro_bru_op  = ro_uop.bru_op;
   assign ro_pc      = ro_uop.pc;
   assign ro_imm     = ro_uop.imm;
   assign ro_prs1    = ro_uop.prs1;
   assign ro_prs1_re = ro_uop.prs1_re;
   assign ro_prs2    = ro_uop.prs2;
   assign ro_prs2_re = ro_uop.prs2_re;
   assign ro_prd     = ro_uop.prd;
   assign ro_prd_we  = ro_uop.prd_we;
   assign ro_rob_id  = ro_uop.rob_id;

endmodule

`default_nettype wire

//--- issue_rs/issue_rs.sv
`timescale 1ns/10ps
`default_nettype none

module issue_rs
#(
   parameter int DEPTH = issue_pkg::RS_DEPTH
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flush,
   input  logic [issue_pkg::PRF_N-1:0] busy,
   uop_if.sink                        disp_rs,
   input  logic                       ro_ready,
   output logic                       ro_valid,
   output issue_pkg::uop_t            ro_uop
);

   logic [DEPTH-1:0] ent_v;                 // Compact, slot 0 oldest
   issue_pkg::uop_t  ent_uop [DEPTH];
   logic [DEPTH-1:0] nxt_v;
   issue_pkg::uop_t  nxt_uop [DEPTH];
   logic [DEPTH-1:0] cand;                  // Valid and operands ready
   logic [DEPTH-1:0] sel_oh;                // Oldest candidate
   logic [DEPTH-1:0] shift;                 // Slot at or above the leaver
   issue_pkg::uop_t  sel_uop;
   logic             out_free;
   logic             issue;
   logic             push;

   // Source ready check against the busy vector
   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         cand[i] = ent_v[i]
                   & (~ent_uop[i].prs1_re | ~busy[ent_uop[i].prs1])
                   & (~ent_uop[i].prs2_re | ~busy[ent_uop[i].prs2]);
      end
   end

   // Lowest slot wins
   always_comb
   begin
      logic seen;
      seen    = 1'b0;
      sel_uop = ent_uop[0];
      for (int i = 0; i < DEPTH; i++)
      begin
         sel_oh[i] = cand[i] & ~seen;
         if (sel_oh[i])
            sel_uop = ent_uop[i];
         seen     = seen | cand[i];
         shift[i] = seen;                    // Prefix OR
      end
   end

   assign out_free = ~ro_valid | ro_ready;  // Output empty or popping
   assign issue    = (|cand) & out_free;

   // Free slot or one leaving
   assign disp_rs.ready = ~ent_v[DEPTH-1] | issue;
   assign push          = disp_rs.valid & disp_rs.ready;

   always_comb
   begin
      logic placed;
      placed  = 1'b0;
      nxt_v   = ent_v;
      nxt_uop = ent_uop;
      if (issue)
      begin
         for (int i = 0; i < DEPTH-1; i++)
         begin
            if (shift[i])
            begin
               nxt_v[i]   = ent_v[i+1];      // Collapse down
               nxt_uop[i] = ent_uop[i+1];
            end
         end
         nxt_v[DEPTH-1] = 1'b0;             // Top always frees
      end
      for (int i = 0; i < DEPTH; i++)
      begin
         if (push && !placed && !nxt_v[i])
         begin
            nxt_v[i]   = 1'b1;               // Youngest behind the rest
            nxt_uop[i] = disp_rs.uop;
            placed     = 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         ent_v <= '0;
      else
         ent_v <= nxt_v;
   end

   always_ff @(posedge clk)
   begin
      ent_uop <= nxt_uop;
   end

   // Register read output stage
   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         ro_valid <= 1'b0;
      else if (issue)
         ro_valid <= 1'b1;
      else if (ro_ready)
         ro_valid <= 1'b0;                  // Popped with nothing behind
   end

   always_ff @(posedge clk)
   begin
      if (issue)
         ro_uop <= sel_uop;
   end

   a_ro_hold: assert property (@(posedge clk) disable iff (!rst_n || flush)
      ro_valid && !ro_ready && !flush |=> ro_valid && $stable(ro_uop));

   // Whatever reaches ro had no busy source when it left
   a_src_ready: assert property (@(posedge clk) disable iff (!rst_n || flush)
      issue && !flush |=> ro_valid
         && (!ro_uop.prs1_re || !$past(busy[sel_uop.prs1]))
         && (!ro_uop.prs2_re || !$past(busy[sel_uop.prs2])));

endmodule

`default_nettype wire

//--- verilog/busy_table.sv
`timescale 1ns/10ps
`default_nettype none

module busy_table
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        flush,
   input  logic                        set_valid,
   input  logic [issue_pkg::PRF_AW-1:0] set_prd,
   input  logic                        wb_valid,
   input  logic [issue_pkg::PRF_AW-1:0] wb_prd,
   output logic [issue_pkg::PRF_N-1:0] busy
);

   // One bit per physical register
   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         busy <= '0;                        // Nothing in flight
      else
      begin
         if (wb_valid)
            busy[wb_prd] <= 1'b0;           // Result written
         if (set_valid)
            busy[set_prd] <= 1'b1;          // New producer
      end
   end

   // Dispatch never renames onto a register still waiting for writeback
   a_set_clr: assert property (@(posedge clk) disable iff (!rst_n)
      !(set_valid && wb_valid && set_prd == wb_prd));

endmodule

`default_nettype wire

//--- verilog/issue_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module issue_dispatch
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        flush,
   input  logic                        in_valid,
   input  issue_pkg::uop_t             in_uop,
   output logic                        in_ready,
   input  logic                        rob_ready,
   input  logic [issue_pkg::ROB_AW-1:0] rob_free_id,
   output logic                        rob_push,
   output logic [issue_pkg::PC_W-1:0]  rob_push_pc,
   output logic [issue_pkg::PRF_AW-1:0] rob_push_prd,
   output logic                        rob_push_prd_we,
   output logic                        rob_push_is_bcc,
   output logic                        rob_push_is_brel,
   output logic                        rob_push_is_breg,
   output logic                        set_valid,
   output logic [issue_pkg::PRF_AW-1:0] set_prd,
   uop_if.source                       disp_rs
);

   logic            d_valid;                // Dispatch register occupied
   issue_pkg::uop_t d_uop;
   issue_pkg::uop_t acc_uop;                // Input with ROB id merged
   logic            settle_q;               // First cycle after reset or flush
   logic            accept;

   // Room in ROB and the register empties or drains this cycle
   assign in_ready = rob_ready & ~settle_q & (~d_valid | disp_rs.ready);
   assign accept   = in_valid & in_ready;

   always_comb
   begin
      acc_uop        = in_uop;
      acc_uop.rob_id = rob_free_id;          // ROB slot granted now
   end

   // ROB push side dropped on flush
   assign rob_push        = accept & ~flush;
   assign rob_push_pc     = in_uop.pc;
   assign rob_push_prd    = in_uop.prd;
   assign rob_push_prd_we = in_uop.prd_we;

   always_comb
   begin
      rob_push_is_bcc  = 1'b0;
      rob_push_is_brel = 1'b0;
      rob_push_is_breg = 1'b0;
      case (in_uop.bru_op)
         issue_pkg::BRU_BEQ,
         issue_pkg::BRU_BNE,
         issue_pkg::BRU_BGT,
         issue_pkg::BRU_BGTU,
         issue_pkg::BRU_BLE,
         issue_pkg::BRU_BLEU:   rob_push_is_bcc  = 1'b1;  // Conditional
         issue_pkg::BRU_JMPREL: rob_push_is_brel = 1'b1;
         issue_pkg::BRU_JMPREG: rob_push_is_breg = 1'b1;
         default:               ;                         // Not a branch
      endcase
   end

   assign set_valid = rob_push & in_uop.prd_we;           // Destination pending
   assign set_prd   = in_uop.prd;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         d_valid  <= 1'b0;
         settle_q <= 1'b1;
      end
      else
      begin
         d_valid  <= accept | (d_valid & ~disp_rs.ready);
         settle_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         d_uop <= acc_uop;                  // Payload only
   end

   assign disp_rs.valid = d_valid;
   assign disp_rs.uop   = d_uop;

   a_push_room: assert property (@(posedge clk) disable iff (!rst_n)
      rob_push |-> rob_ready);

endmodule

`default_nettype wire

//--- common/uop_if.sv
`timescale 1ns/10ps
`default_nettype none

// Micro-op link with valid/ready flow control
interface uop_if;

   logic            valid;                  // Producer has a micro-op
   logic            ready;                  // Consumer takes it this cycle
   issue_pkg::uop_t uop;                    // Held while stalled

   modport source
   (
      output valid,
      output uop,
      input  ready
   );

   modport sink
   (
      input  valid,
      input  uop,
      output ready
   );

endinterface

`default_nettype wire

//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

   localparam int PRF_AW   = 5;              // 32 physical registers
   localparam int PRF_N    = 1 << PRF_AW;
   localparam int ROB_AW   = 4;              // ROB entry id
   localparam int DW       = 32;             // Immediate width
   localparam int PC_W     = 30;             // Word address
   localparam int RS_DEPTH = 4;              // Station entries
   localparam int ALU_OPW  = 4;

   // Branch unit opcodes
   typedef enum logic [3:0]
   {
      BRU_NONE   = 4'd0,
      BRU_BEQ    = 4'd1,
      BRU_BNE    = 4'd2,
      BRU_BGT    = 4'd3,
      BRU_BGTU   = 4'd4,
      BRU_BLE    = 4'd5,
      BRU_BLEU   = 4'd6,
      BRU_JMPREL = 4'd7,                     // PC relative jump
      BRU_JMPREG = 4'd8                      // Register indirect jump
   } bru_op_t;

   // One renamed micro-op as it travels through issue
   typedef struct packed
   {
      logic [ALU_OPW-1:0] alu_op;
      bru_op_t            bru_op;
      logic [PC_W-1:0]    pc;
      logic [DW-1:0]      imm;
      logic [PRF_AW-1:0]  prs1;              // Physical source 1
      logic               prs1_re;           // Source 1 is read
      logic [PRF_AW-1:0]  prs2;
      logic               prs2_re;
      logic [PRF_AW-1:0]  prd;               // Physical destination
      logic               prd_we;
      logic [ROB_AW-1:0]  rob_id;            // Filled in at dispatch
   } uop_t;

endpackage

`default_nettype wire
